//--- sata_phy_pkg.sv
`default_nettype none

package sata_phy_pkg;

   // Width of the phase-align step counter
   localparam int TIMER_W = 16;

   // One 32-bit lane word with a K-flag per byte
   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  k;
   } gtp_word_t;

   // Transceiver drive and equalization fields taken from the tuning word
   typedef struct packed {
      logic [2:0] loopback;
      logic [2:0] txdiffctrl;
      logic [2:0] txpreemphasis;
      logic [1:0] rxeqmix;
   } gtp_tune_t;

   // Codes reported on the debug bus for each recognized primitive
   typedef enum logic [7:0] {
      PRIM_NONE  = 8'd0,
      PRIM_ALIGN = 8'd1,
      PRIM_SYNC  = 8'd2,
      PRIM_X_RDY = 8'd3,
      PRIM_R_RDY = 8'd4,
      PRIM_R_IP  = 8'd5,
      PRIM_R_OK  = 8'd6,
      PRIM_R_ERR = 8'd7,
      PRIM_SOF   = 8'd8,
      PRIM_EOF   = 8'd9,
      PRIM_WTRM  = 8'd10,
      PRIM_HOLD  = 8'd11,
      PRIM_HOLDA = 8'd12,
      PRIM_CONT  = 8'd13
   } prim_code_e;

   // Primitive dwords as seen on the 32-bit interface, K28.x in byte 0
   localparam logic [31:0] PRIM_ALIGN_WORD = 32'h7B4A_4ABC;
   localparam logic [31:0] PRIM_SYNC_WORD  = 32'hB5B5_957C;
   localparam logic [31:0] PRIM_X_RDY_WORD = 32'h5757_B57C;
   localparam logic [31:0] PRIM_R_RDY_WORD = 32'h4A4A_957C;
   localparam logic [31:0] PRIM_R_IP_WORD  = 32'h5555_B57C;
   localparam logic [31:0] PRIM_R_OK_WORD  = 32'h3535_B57C;
   localparam logic [31:0] PRIM_R_ERR_WORD = 32'h5656_B57C;
   localparam logic [31:0] PRIM_SOF_WORD   = 32'h3737_B57C;
   localparam logic [31:0] PRIM_EOF_WORD   = 32'hD5D5_B57C;
   localparam logic [31:0] PRIM_WTRM_WORD  = 32'h5858_B57C;
   localparam logic [31:0] PRIM_HOLD_WORD  = 32'hD5D5_AA7C;
   localparam logic [31:0] PRIM_HOLDA_WORD = 32'h9595_AA7C;
   localparam logic [31:0] PRIM_CONT_WORD  = 32'h9999_AA7C;

   // Only byte 0 carries a control character in a primitive
   localparam logic [3:0] PRIM_K_FLAGS = 4'b0001;

   // Debug view of one lane, both words and their primitive codes
   typedef struct packed {
      gtp_word_t  tx_word;
      gtp_word_t  rx_word;
      prim_code_e tx_prim;
      prim_code_e rx_prim;
   } dbg_bus_t;

   // Transmit phase-align sequence
   typedef enum logic [1:0] {
      WAIT_RESET = 2'd0,
      ALIGN      = 2'd1,
      SET_PHASE  = 2'd2,
      DONE       = 2'd3
   } txsync_state_e;

endpackage

`default_nettype wire

//--- phase_align_timer.sv
`default_nettype none

module phase_align_timer (
   input  logic                             tile0_txusrclk20_i,
   input  logic                             tile0_resetdone0_i,
   input  logic                             start_i,
   input  logic [sata_phy_pkg::TIMER_W-1:0] load_i,
   output logic                             expired_o
);

   logic [sata_phy_pkg::TIMER_W-1:0] cnt_q;
   logic                             run_q;

   // Loading N-1 puts the expiry cycle N cycles after the start cycle
   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         cnt_q <= '0;
         run_q <= 1'b0;
      end
      else if (start_i)
      begin
         cnt_q <= load_i - 1'b1;
         run_q <= (load_i != '0);
      end
      else if (run_q)
      begin
         if (cnt_q == '0)
            run_q <= 1'b0;
         else
            cnt_q <= cnt_q - 1'b1;
      end
   end

   // High for the last counted cycle only
   assign expired_o = run_q && (cnt_q == '0);

endmodule

`default_nettype wire

//--- tx_phase_align_fsm.sv
`default_nettype none

module tx_phase_align_fsm #(
   parameter int BYPASS_TXBUF      = 1,
   parameter int ALIGN_WAIT_CYCLES = 32,
   parameter int SETPHASE_CYCLES   = 128
) (
   input  logic                             tile0_txusrclk20_i,
   input  logic                             tile0_resetdone0_i,
   input  logic                             timer_expired_i,
   output logic                             timer_start_o,
   output logic [sata_phy_pkg::TIMER_W-1:0] timer_load_o,
   output logic                             txenpmaphasealign_o,
   output logic                             txpmasetphase_o,
   output logic                             tx_sync_done_o
);

   localparam logic [sata_phy_pkg::TIMER_W-1:0] ALIGN_LOAD =
      ALIGN_WAIT_CYCLES[sata_phy_pkg::TIMER_W-1:0];
   localparam logic [sata_phy_pkg::TIMER_W-1:0] SETPHASE_LOAD =
      SETPHASE_CYCLES[sata_phy_pkg::TIMER_W-1:0];
   // Phase alignment is only sequenced when the TX buffer is bypassed
   localparam bit SEQ_EN = (BYPASS_TXBUF == 1);

   logic                        resetdone_meta_q;
   logic                        resetdone_sync_q;
   sata_phy_pkg::txsync_state_e state_q;
   sata_phy_pkg::txsync_state_e state_nxt;

   // Bring the reset-done level into the user clock domain
   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         resetdone_meta_q <= 1'b0;
         resetdone_sync_q <= 1'b0;
      end
      else
      begin
         resetdone_meta_q <= 1'b1;
         resetdone_sync_q <= resetdone_meta_q;
      end
   end

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         sata_phy_pkg::WAIT_RESET:
            if (resetdone_sync_q)
               state_nxt = SEQ_EN ? sata_phy_pkg::ALIGN : sata_phy_pkg::DONE;
         sata_phy_pkg::ALIGN:
            if (timer_expired_i)
               state_nxt = sata_phy_pkg::SET_PHASE;
         sata_phy_pkg::SET_PHASE:
            if (timer_expired_i)
               state_nxt = sata_phy_pkg::DONE;
         default:
            state_nxt = state_q;
      endcase
   end

   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
         state_q <= sata_phy_pkg::WAIT_RESET;
      else
         state_q <= state_nxt;
   end

   // Timer restarts on entry to each timed step
   assign timer_start_o = (state_nxt != state_q) && (state_nxt != sata_phy_pkg::DONE);
   assign timer_load_o  = (state_q == sata_phy_pkg::WAIT_RESET) ? ALIGN_LOAD : SETPHASE_LOAD;

   assign txenpmaphasealign_o = (state_q == sata_phy_pkg::ALIGN) ||
                                (state_q == sata_phy_pkg::SET_PHASE) ||
                                (SEQ_EN && (state_q == sata_phy_pkg::DONE));
   assign txpmasetphase_o     = (state_q == sata_phy_pkg::SET_PHASE);
   assign tx_sync_done_o      = (state_q == sata_phy_pkg::DONE);

endmodule

`default_nettype wire

//--- sata_prim_classifier.sv
`default_nettype none

module sata_prim_classifier (
   input  sata_phy_pkg::gtp_word_t  word_i,
   output sata_phy_pkg::prim_code_e prim_o
);

   always_comb
   begin
      prim_o = sata_phy_pkg::PRIM_NONE;
      // Data that merely looks like a primitive is ignored without the K-flag
      if (word_i.k == sata_phy_pkg::PRIM_K_FLAGS)
      begin
         case (word_i.data)
            sata_phy_pkg::PRIM_ALIGN_WORD:
               prim_o = sata_phy_pkg::PRIM_ALIGN;
            sata_phy_pkg::PRIM_SYNC_WORD:
               prim_o = sata_phy_pkg::PRIM_SYNC;
            sata_phy_pkg::PRIM_X_RDY_WORD:
               prim_o = sata_phy_pkg::PRIM_X_RDY;
            sata_phy_pkg::PRIM_R_RDY_WORD:
               prim_o = sata_phy_pkg::PRIM_R_RDY;
            sata_phy_pkg::PRIM_R_IP_WORD:
               prim_o = sata_phy_pkg::PRIM_R_IP;
            sata_phy_pkg::PRIM_R_OK_WORD:
               prim_o = sata_phy_pkg::PRIM_R_OK;
            sata_phy_pkg::PRIM_R_ERR_WORD:
               prim_o = sata_phy_pkg::PRIM_R_ERR;
            sata_phy_pkg::PRIM_SOF_WORD:
               prim_o = sata_phy_pkg::PRIM_SOF;
            sata_phy_pkg::PRIM_EOF_WORD:
               prim_o = sata_phy_pkg::PRIM_EOF;
            sata_phy_pkg::PRIM_WTRM_WORD:
               prim_o = sata_phy_pkg::PRIM_WTRM;
            sata_phy_pkg::PRIM_HOLD_WORD:
               prim_o = sata_phy_pkg::PRIM_HOLD;
            sata_phy_pkg::PRIM_HOLDA_WORD:
               prim_o = sata_phy_pkg::PRIM_HOLDA;
            sata_phy_pkg::PRIM_CONT_WORD:
               prim_o = sata_phy_pkg::PRIM_CONT;
            default:
               prim_o = sata_phy_pkg::PRIM_NONE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- gtp_lane_regs.sv
`default_nettype none

module gtp_lane_regs (
   input  logic                     tile0_txusrclk20_i,
   input  logic                     tile0_resetdone0_i,
   input  logic [31:0]              gtx_tune_i,
   input  sata_phy_pkg::gtp_word_t  tx_word_i,
   input  sata_phy_pkg::gtp_word_t  rx_word_i,
   output sata_phy_pkg::gtp_tune_t  tune_o,
   output sata_phy_pkg::gtp_word_t  tx_mon_o,
   output sata_phy_pkg::gtp_word_t  rx_mon_o,
   output sata_phy_pkg::dbg_bus_t   dbg_o
);

   sata_phy_pkg::prim_code_e tx_prim;
   sata_phy_pkg::prim_code_e rx_prim;
   sata_phy_pkg::gtp_tune_t  tune_d;
   sata_phy_pkg::dbg_bus_t   dbg_d;

   // Codes come from the incoming words so they line up with the registered copies
   sata_prim_classifier u_tx_classifier (
      .word_i (tx_word_i),
      .prim_o (tx_prim)
   );

   sata_prim_classifier u_rx_classifier (
      .word_i (rx_word_i),
      .prim_o (rx_prim)
   );

   // Field layout of the tuning word, bits 15:9 and 31:18 are spare
   always_comb
   begin
      tune_d.loopback      = gtx_tune_i[2:0];
      tune_d.txdiffctrl    = gtx_tune_i[5:3];
      tune_d.txpreemphasis = gtx_tune_i[8:6];
      tune_d.rxeqmix       = gtx_tune_i[17:16];
   end

   always_comb
   begin
      dbg_d.tx_word = tx_word_i;
      dbg_d.rx_word = rx_word_i;
      dbg_d.tx_prim = tx_prim;
      dbg_d.rx_prim = rx_prim;
   end

   // One stage for everything, no stall
   always_ff @(posedge tile0_txusrclk20_i or negedge tile0_resetdone0_i)
   begin
      if (!tile0_resetdone0_i)
      begin
         tune_o   <= '0;
         tx_mon_o <= '0;
         rx_mon_o <= '0;
         dbg_o    <= '0;
      end
      else
      begin
         tune_o   <= tune_d;
         tx_mon_o <= tx_word_i;
         rx_mon_o <= rx_word_i;
         dbg_o    <= dbg_d;
      end
   end

endmodule

`default_nettype wire

//--- sata_gtp_lane_top.sv
`default_nettype none

module sata_gtp_lane_top #(
   parameter int BYPASS_TXBUF      = 1,
   parameter int SATA_SPEED        = 1,
   parameter int ALIGN_WAIT_CYCLES = 32
) (
   input  logic                     tile0_txusrclk20_i,
   input  logic                     tile0_resetdone0_i,
   input  logic [31:0]              gtx_tune_i,
   input  sata_phy_pkg::gtp_word_t  tx_word_i,
   input  sata_phy_pkg::gtp_word_t  rx_word_i,
   output sata_phy_pkg::gtp_tune_t  tune_o,
   output logic                     txenpmaphasealign_o,
   output logic                     txpmasetphase_o,
   output logic                     tx_sync_done_o,
   output sata_phy_pkg::gtp_word_t  tx_mon_o,
   output sata_phy_pkg::gtp_word_t  rx_mon_o,
   output sata_phy_pkg::dbg_bus_t   dbg_o
);

   // Set-phase step is halved at the higher line rate
   localparam int SETPHASE_CYCLES = (SATA_SPEED == 2) ? 64 : 128;

   logic                             timer_start;
   logic [sata_phy_pkg::TIMER_W-1:0] timer_load;
   logic                             timer_expired;

   tx_phase_align_fsm #(
      .BYPASS_TXBUF      (BYPASS_TXBUF),
      .ALIGN_WAIT_CYCLES (ALIGN_WAIT_CYCLES),
      .SETPHASE_CYCLES   (SETPHASE_CYCLES)
   ) u_txsync (
      .tile0_txusrclk20_i  (tile0_txusrclk20_i),
      .tile0_resetdone0_i  (tile0_resetdone0_i),
      .timer_expired_i     (timer_expired),
      .timer_start_o       (timer_start),
      .timer_load_o        (timer_load),
      .txenpmaphasealign_o (txenpmaphasealign_o),
      .txpmasetphase_o     (txpmasetphase_o),
      .tx_sync_done_o      (tx_sync_done_o)
   );

   phase_align_timer u_timer (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .start_i            (timer_start),
      .load_i             (timer_load),
      .expired_o          (timer_expired)
   );

   gtp_lane_regs u_regs (
      .tile0_txusrclk20_i (tile0_txusrclk20_i),
      .tile0_resetdone0_i (tile0_resetdone0_i),
      .gtx_tune_i         (gtx_tune_i),
      .tx_word_i          (tx_word_i),
      .rx_word_i          (rx_word_i),
      .tune_o             (tune_o),
      .tx_mon_o           (tx_mon_o),
      .rx_mon_o           (rx_mon_o),
      .dbg_o              (dbg_o)
   );

endmodule

`default_nettype wire

//--- sata_gtp_lane_properties.sv
`default_nettype none

module sata_gtp_lane_properties (
   input logic                    tile0_txusrclk20_i,
   input logic                    tile0_resetdone0_i,
   input logic                    txenpmaphasealign_i,
   input logic                    txpmasetphase_i,
   input logic                    tx_sync_done_i,
   input sata_phy_pkg::gtp_tune_t tune_i,
   input sata_phy_pkg::gtp_word_t tx_mon_i,
   input sata_phy_pkg::gtp_word_t rx_mon_i,
   input sata_phy_pkg::dbg_bus_t  dbg_i
);

   // Latched by any assertion failure, read back by the testbench
   logic violation_seen = 1'b0;

   a_setphase_needs_align : assert property (@(posedge tile0_txusrclk20_i)
      disable iff (!tile0_resetdone0_i) txpmasetphase_i |-> txenpmaphasealign_i)
      else begin violation_seen = 1'b1; $error("set phase without align enable"); end

   a_done_no_setphase : assert property (@(posedge tile0_txusrclk20_i)
      disable iff (!tile0_resetdone0_i) tx_sync_done_i |-> !txpmasetphase_i)
      else begin violation_seen = 1'b1; $error("set phase high while done"); end

   // Done is sticky until the next reset
   a_done_sticky : assert property (@(posedge tile0_txusrclk20_i)
      disable iff (!tile0_resetdone0_i) tx_sync_done_i |=> tx_sync_done_i)
      else begin violation_seen = 1'b1; $error("sync done fell outside reset"); end

   a_reset_clears : assert property (@(posedge tile0_txusrclk20_i)
      !tile0_resetdone0_i |-> (!txenpmaphasealign_i && !txpmasetphase_i && !tx_sync_done_i &&
                               tune_i == '0 && tx_mon_i == '0 && rx_mon_i == '0 && dbg_i == '0))
      else begin violation_seen = 1'b1; $error("output not cleared in reset"); end

endmodule

bind sata_gtp_lane_top sata_gtp_lane_properties u_props (
   .tile0_txusrclk20_i  (tile0_txusrclk20_i),
   .tile0_resetdone0_i  (tile0_resetdone0_i),
   .txenpmaphasealign_i (txenpmaphasealign_o),
   .txpmasetphase_i     (txpmasetphase_o),
   .tx_sync_done_i      (tx_sync_done_o),
   .tune_i              (tune_o),
   .tx_mon_i            (tx_mon_o),
   .rx_mon_i            (rx_mon_o),
   .dbg_i               (dbg_o)
);

`default_nettype wire

//--- tb_sata_gtp_lane.sv
`default_nettype none

module tb_sata_gtp_lane;

   localparam int NUM_VEC     = 20;
   localparam int VEC_WORDS   = 7;
   localparam int NUM_RANDOM  = 200;
   localparam int PHASE_LIMIT = 400;

   logic                     txusrclk20;
   logic                     resetdone;
   logic [31:0]              gtx_tune;
   sata_phy_pkg::gtp_word_t  tx_word;
   sata_phy_pkg::gtp_word_t  rx_word;
   sata_phy_pkg::gtp_tune_t  tune;
   logic                     txenpmaphasealign;
   logic                     txpmasetphase;
   logic                     tx_sync_done;
   sata_phy_pkg::gtp_word_t  tx_mon;
   sata_phy_pkg::gtp_word_t  rx_mon;
   sata_phy_pkg::dbg_bus_t   dbg;

   // Columns per vector are tune, tx data, tx K, rx data, rx K, tx code and rx code
   logic [31:0] stim_mem [0:NUM_VEC*VEC_WORDS-1];
   logic [15:0] lfsr_state;
   int          cycles;

   sata_gtp_lane_top dut_i (
      .tile0_txusrclk20_i  (txusrclk20),
      .tile0_resetdone0_i  (resetdone),
      .gtx_tune_i          (gtx_tune),
      .tx_word_i           (tx_word),
      .rx_word_i           (rx_word),
      .tune_o              (tune),
      .txenpmaphasealign_o (txenpmaphasealign),
      .txpmasetphase_o     (txpmasetphase),
      .tx_sync_done_o      (tx_sync_done),
      .tx_mon_o            (tx_mon),
      .rx_mon_o            (rx_mon),
      .dbg_o               (dbg)
   );

   initial
   begin
      txusrclk20 = 1'b0;
      forever #50 txusrclk20 = ~txusrclk20;
   end

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_value(input string name, input logic [127:0] exp,
                              input logic [127:0] act);
      if (exp !== act)
      begin
         $display("ERR %s expected %0h actual %0h", name, exp, act);
         abort_run();
      end
   endtask

   // A bound assertion failure ends the run at the next falling edge
   always @(negedge txusrclk20)
   begin
      if (dut_i.u_props.violation_seen === 1'b1)
      begin
         $display("a bound property assertion failed during the run");
         abort_run();
      end
   end

   function automatic logic phase_bit(input int sel);
      case (sel)
         0:       return txenpmaphasealign;
         1:       return txpmasetphase;
         default: return tx_sync_done;
      endcase
   endfunction

   // Counts falling edges since reset release until the selected output is high
   task automatic wait_phase_output(input string name, input int sel, input int exp_cycles);
      while (phase_bit(sel) !== 1'b1)
      begin
         if (cycles >= PHASE_LIMIT)
         begin
            $display("%s never went high after reset release", name);
            abort_run();
         end
         @(negedge txusrclk20);
         cycles++;
      end
      check_value({name, " rise cycle"}, exp_cycles, cycles);
   endtask

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic next_random_word(output logic [31:0] w);
      w = '0;
      for (int b = 0; b < 32; b++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         w = {w[30:0], lfsr_state[0]};
      end
   endtask

   task automatic drive_vector(input int i);
      gtx_tune     = stim_mem[i*VEC_WORDS];
      tx_word.data = stim_mem[i*VEC_WORDS+1];
      tx_word.k    = stim_mem[i*VEC_WORDS+2][3:0];
      rx_word.data = stim_mem[i*VEC_WORDS+3];
      rx_word.k    = stim_mem[i*VEC_WORDS+4][3:0];
   endtask

   task automatic check_vector(input int i);
      int          b;
      logic [31:0] t;
      b = i * VEC_WORDS;
      t = stim_mem[b];
      check_value($sformatf("tune_o vec %0d", i), {t[2:0], t[5:3], t[8:6], t[17:16]}, tune);
      check_value($sformatf("tx_mon_o vec %0d", i), {stim_mem[b+1], stim_mem[b+2][3:0]}, tx_mon);
      check_value($sformatf("rx_mon_o vec %0d", i), {stim_mem[b+3], stim_mem[b+4][3:0]}, rx_mon);
      check_value($sformatf("dbg_o vec %0d", i),
                  {stim_mem[b+1], stim_mem[b+2][3:0], stim_mem[b+3], stim_mem[b+4][3:0],
                   stim_mem[b+5][7:0], stim_mem[b+6][7:0]}, dbg);
      // Sequence must hold its final state
      check_value("align enable held", 1, txenpmaphasealign);
      check_value("set phase held low", 0, txpmasetphase);
   endtask

   task automatic run_random_words();
      logic [31:0] rx_d;
      logic [31:0] tx_d;
      next_random_word(rx_d);
      next_random_word(tx_d);
      rx_word = '{data: rx_d, k: 4'b0000};
      tx_word = '{data: tx_d, k: 4'b0000};
      for (int n = 0; n < NUM_RANDOM; n++)
      begin
         @(negedge txusrclk20);
         check_value($sformatf("rx_mon_o random %0d", n), {rx_d, 4'b0000}, rx_mon);
         check_value($sformatf("rx_prim random %0d", n), 0, dbg.rx_prim);
         check_value($sformatf("dbg_o random %0d", n), {tx_d, 4'b0, rx_d, 4'b0, 16'h0}, dbg);
         next_random_word(rx_d);
         next_random_word(tx_d);
         rx_word = '{data: rx_d, k: 4'b0000};
         tx_word = '{data: tx_d, k: 4'b0000};
      end
   endtask

   initial
   begin
      resetdone  = 1'b0;
      gtx_tune   = 32'hFFFF_FFFF;
      tx_word    = '{data: 32'h7B4A_4ABC, k: 4'b0001};
      rx_word    = '{data: 32'hB5B5_957C, k: 4'b0001};
      lfsr_state = 16'd7945;
      cycles     = 0;
      for (int i = 0; i < NUM_VEC*VEC_WORDS; i++)
         stim_mem[i] = 'x;
      $readmemh("sata_gtp_lane_stim.txt", stim_mem);
      for (int i = 0; i < NUM_VEC*VEC_WORDS; i++)
      begin
         if ($isunknown(stim_mem[i]))
         begin
            $display("stimulus file is missing or has too few vectors");
            abort_run();
         end
      end

      // Inputs are busy but everything must stay cleared
      repeat (4) @(negedge txusrclk20);
      check_value("align enable in reset", 0, txenpmaphasealign);
      check_value("set phase in reset", 0, txpmasetphase);
      check_value("sync done in reset", 0, tx_sync_done);
      check_value("tune_o in reset", 0, tune);
      check_value("tx_mon_o in reset", 0, tx_mon);
      check_value("rx_mon_o in reset", 0, rx_mon);
      check_value("dbg_o in reset", 0, dbg);
      @(negedge txusrclk20);
      resetdone = 1'b1;

      wait_phase_output("align enable", 0, 3);
      check_value("set phase during align", 0, txpmasetphase);
      wait_phase_output("set phase", 1, 3 + 32);
      check_value("align enable during set phase", 1, txenpmaphasealign);
      wait_phase_output("sync done", 2, 3 + 32 + 128);
      check_value("align enable when done", 1, txenpmaphasealign);
      check_value("set phase when done", 0, txpmasetphase);

      drive_vector(0);
      for (int i = 0; i < NUM_VEC; i++)
      begin
         @(negedge txusrclk20);
         check_vector(i);
         if (i + 1 < NUM_VEC)
            drive_vector(i + 1);
      end
      run_random_words();

      if (dut_i.u_props.violation_seen)
      begin
         $display("a bound property assertion failed during the run");
         abort_run();
      end
      else
      begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- sata_gtp_lane_stim.txt
// tune  tx_data  tx_k  rx_data  rx_k  tx_prim  rx_prim
// K columns are the 4-bit K-flags, prim columns are the expected primitive codes
00000000 7B4A4ABC 1 B5B5957C 1 01 02
0003FFFF 5757B57C 1 4A4A957C 1 03 04
00010049 5555B57C 1 3535B57C 1 05 06
000201C7 5656B57C 1 3737B57C 1 07 08
FFFFFFFF D5D5B57C 1 5858B57C 1 09 0A
12345678 D5D5AA7C 1 9595AA7C 1 0B 0C
9ABCDEF0 9999AA7C 1 7B4A4ABC 1 0D 01
0000002A 7B4A4ABC 0 B5B5957C 3 00 00
00020155 5757B57C F 4A4A957C 2 00 00
DEADBEEF 12345678 0 CAFEF00D 0 00 00
0001FE00 7B4A4ABD 1 B5B5957D 1 00 00
00030092 3535B57C 1 5555B57C 1 06 05
000000DB 9595AA7C 8 D5D5AA7C 1 00 0B
A5A5A5A5 D5D5B57C 1 5656B57C 9 09 00
5A5A5A5A 4A4A957C 1 5757B57C 1 04 03
00010124 5858B57C 1 9999AA7C 1 0A 0D
0002016D 3737B57C 1 D5D5B57C 1 08 09
00000000 00000000 0 00000000 0 00 00
0003FFC0 B5B5957C 1 7B4A4ABC 0 02 00
7FFE0007 9999AA7C 1 3535B57C 1 0D 06

//--- verilog.f
sata_phy_pkg.sv
phase_align_timer.sv
tx_phase_align_fsm.sv
sata_prim_classifier.sv
gtp_lane_regs.sv
sata_gtp_lane_top.sv
sata_gtp_lane_properties.sv
tb_sata_gtp_lane.sv
